// File: all.f
+incdir+src
src/cpu_pkg.sv
src/InstructionFetch.sv
src/RegisterFile.sv
src/DecodeStage.sv
src/ExecuteStage.sv
src/MemoryStage.sv
src/CPU.sv
tests/ClockGen.sv
tests/cpu_checker.sv
tests/CpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= CpuTb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "sim: FAIL"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "sim: FAIL, run ended early"; exit 1; \
	fi
	@echo "sim: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/CpuTb.sv
`default_nettype none

`include "cpu_defs.svh"

module CpuTb;

  localparam int resetCycles = 16;
  localparam int drainCycles = 8;
  localparam int imemAw = $clog2(`IMEM_DEPTH);
  localparam int dmemAw = $clog2(`DMEM_DEPTH);
  localparam int randomLen = 60;
  // fixed programs add up to 4 + 10 + 6 + 9 + 3 words
  // every run reloads all of imem
  localparam int watchdogCycles =
    6 * (1 + resetCycles + `IMEM_DEPTH + drainCycles) + 32 + randomLen + 100;
  // addi x0, x0, 0
  localparam cpu_pkg::word_t nopWord = 32'h0000_0013;

  logic              clk;
  logic              rstN;
  logic              imemWrite;
  logic [imemAw-1:0] imemAddr;
  cpu_pkg::word_t    imemData;
  cpu_pkg::retire_t  retire;

  cpu_pkg::word_t   prog[$];
  cpu_pkg::retire_t expected[$];
  cpu_pkg::word_t   modelRegs[`REG_COUNT];
  // the data memory has no reset and the model keeps it across tests
  cpu_pkg::word_t   modelMem[`DMEM_DEPTH] = '{default: '0};
  int errorCount = 0;
  int checkCount = 0;
  int testCount = 0;

  ClockGen #(.period(8)) u_clk (.clk(clk));

  CPU u_dut (
    .clk(clk),
    .rstN(rstN),
    .imemWrite(imemWrite),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .retire(retire)
  );

  bind CPU cpu_checker u_checker (.clk(clk), .rstN(rstN), .retire(retire));

  // RV32I encoders
  function automatic cpu_pkg::word_t regOp(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input cpu_pkg::regIndex_t rd, rs1, rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic cpu_pkg::word_t addi(input cpu_pkg::regIndex_t rd, rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic cpu_pkg::word_t lw(input cpu_pkg::regIndex_t rd, rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic cpu_pkg::word_t sw(input cpu_pkg::regIndex_t rs2, rs1,
                                        input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  task automatic reportFailure(input string testName, input string msg);
    $display("ERROR %s: %s", testName, msg);
    errorCount++;
  endtask

  task automatic compareWord(input string testName, input cpu_pkg::word_t exp,
                             input cpu_pkg::word_t act);
    checkCount++;
    if (exp !== act) begin
      $display("MISMATCH %s data expected %h actual %h", testName, exp, act);
      errorCount++;
    end
  endtask

  task automatic compareIndex(input string testName, input cpu_pkg::regIndex_t exp,
                              input cpu_pkg::regIndex_t act);
    checkCount++;
    if (exp !== act) begin
      $display("MISMATCH %s rd expected x%0d actual x%0d", testName, exp, act);
      errorCount++;
    end
  endtask

  task automatic compareBit(input string testName, input logic exp, input logic act);
    checkCount++;
    if (exp !== act) begin
      $display("MISMATCH %s regWrite expected %b actual %b", testName, exp, act);
      errorCount++;
    end
  endtask

  // golden model with one retire record per instruction in program order
  task automatic modelProgram();
    cpu_pkg::word_t     ins;
    cpu_pkg::word_t     a;
    cpu_pkg::word_t     b;
    cpu_pkg::word_t     result;
    cpu_pkg::word_t     addr;
    cpu_pkg::regIndex_t rd;
    logic               writes;
    cpu_pkg::retire_t   r;
    expected.delete();
    foreach (modelRegs[i]) begin
      modelRegs[i] = '0;
    end
    foreach (prog[k]) begin
      ins = prog[k];
      rd = ins[11:7];
      a = modelRegs[ins[19:15]];
      b = modelRegs[ins[24:20]];
      writes = 1'b1;
      result = '0;
      case (ins[6:0])
        7'b0110011: begin
          case ({ins[31:25], ins[14:12]})
            10'b0000000_000: result = a + b;
            10'b0100000_000: result = a - b;
            10'b0000000_111: result = a & b;
            10'b0000000_110: result = a | b;
            10'b0000000_100: result = a ^ b;
            default:         writes = 1'b0;
          endcase
        end
        7'b0010011: result = a + {{20{ins[31]}}, ins[31:20]};
        7'b0000011: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          result = modelMem[addr[dmemAw+1:2]];
        end
        7'b0100011: begin
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          modelMem[addr[dmemAw+1:2]] = b;
          // a store shows its address on retire
          result = addr;
          writes = 1'b0;
          rd = '0;
        end
        default: writes = 1'b0;
      endcase
      r.valid = 1'b1;
      r.regWrite = writes && (rd != '0);
      r.rd = rd;
      r.data = result;
      if (r.regWrite) begin
        modelRegs[rd] = result;
      end
      expected.push_back(r);
    end
  endtask

  // reset, load imem, release and follow retire until the pipeline drains
  task automatic runProgram(input string testName);
    int idx;
    int errorsBefore;
    errorsBefore = errorCount;
    idx = 0;
    modelProgram();
    @(posedge clk);
    rstN <= 1'b0;
    imemWrite <= 1'b0;
    repeat (resetCycles) begin
      @(negedge clk);
      if (retire.valid) begin
        reportFailure(testName, "retire valid while reset is held");
      end
      @(posedge clk);
    end
    // the whole imem is rewritten so old programs leave nothing behind
    for (int a = 0; a < `IMEM_DEPTH; a++) begin
      imemWrite <= 1'b1;
      imemAddr <= a[imemAw-1:0];
      imemData <= (a < prog.size()) ? prog[a] : '0;
      @(posedge clk);
    end
    imemWrite <= 1'b0;
    rstN <= 1'b1;
    for (int cyc = 1; cyc <= prog.size() + drainCycles; cyc++) begin
      @(posedge clk);
      @(negedge clk);
      if (retire.valid) begin
        if (idx >= expected.size()) begin
          reportFailure(testName, $sformatf("extra retire on edge %0d", cyc));
        end else begin
          // word k reaches write-back on edge k + 4
          if (cyc != idx + 4) begin
            reportFailure(testName, $sformatf("instruction %0d retired on edge %0d, not %0d",
                                              idx, cyc, idx + 4));
          end
          compareBit(testName, expected[idx].regWrite, retire.regWrite);
          compareIndex(testName, expected[idx].rd, retire.rd);
          compareWord(testName, expected[idx].data, retire.data);
        end
        idx++;
      end
    end
    if (idx < expected.size()) begin
      reportFailure(testName, $sformatf("only %0d of %0d instructions retired",
                                        idx, expected.size()));
    end
    testCount++;
    $display("test %s done, %0d errors", testName, errorCount - errorsBefore);
  endtask

  task automatic resetBehavior();
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd5));
    prog.push_back(nopWord);
    prog.push_back(nopWord);
    prog.push_back(addi(5'd2, 5'd1, 12'd3));
    runProgram("reset");
  endtask

  task automatic registerOps();
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd100));
    prog.push_back(addi(5'd2, 5'd0, 12'hfdb));
    prog.push_back(addi(5'd3, 5'd0, 12'h5a5));
    prog.push_back(nopWord);
    prog.push_back(nopWord);
    prog.push_back(regOp(7'h00, 3'd0, 5'd4, 5'd1, 5'd2));
    prog.push_back(regOp(7'h20, 3'd0, 5'd5, 5'd1, 5'd2));
    prog.push_back(regOp(7'h00, 3'd7, 5'd6, 5'd1, 5'd3));
    prog.push_back(regOp(7'h00, 3'd6, 5'd7, 5'd2, 5'd3));
    prog.push_back(regOp(7'h00, 3'd4, 5'd8, 5'd1, 5'd3));
    runProgram("registerOps");
  endtask

  task automatic zeroRegister();
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd7));
    prog.push_back(addi(5'd0, 5'd0, 12'd55));
    prog.push_back(nopWord);
    prog.push_back(nopWord);
    prog.push_back(regOp(7'h00, 3'd0, 5'd2, 5'd0, 5'd1));
    prog.push_back(regOp(7'h00, 3'd0, 5'd3, 5'd0, 5'd0));
    runProgram("zeroRegister");
  endtask

  task automatic loadStore();
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'h123));
    prog.push_back(addi(5'd2, 5'd0, 12'd16));
    prog.push_back(addi(5'd5, 5'd0, 12'hfff));
    prog.push_back(nopWord);
    prog.push_back(sw(5'd1, 5'd2, 12'd8));
    prog.push_back(sw(5'd5, 5'd2, 12'd12));
    prog.push_back(lw(5'd3, 5'd2, 12'd8));
    prog.push_back(lw(5'd4, 5'd2, 12'd12));
    prog.push_back(nopWord);
    runProgram("loadStore");
  endtask

  // two nops after every instruction keep producers and consumers apart
  task automatic randomProgram();
    int unsigned        r;
    cpu_pkg::regIndex_t rd;
    cpu_pkg::regIndex_t rs1;
    cpu_pkg::regIndex_t rs2;
    prog.delete();
    for (int g = 0; g < randomLen / 3; g++) begin
      r = $urandom;
      rd = r[4:0];
      rs1 = r[9:5];
      rs2 = r[14:10];
      case (r[31:29])
        3'd0:    prog.push_back(regOp(7'h00, 3'd0, rd, rs1, rs2));
        3'd1:    prog.push_back(regOp(7'h20, 3'd0, rd, rs1, rs2));
        3'd2:    prog.push_back(regOp(7'h00, 3'd7, rd, rs1, rs2));
        3'd3:    prog.push_back(regOp(7'h00, 3'd6, rd, rs1, rs2));
        3'd4:    prog.push_back(regOp(7'h00, 3'd4, rd, rs1, rs2));
        default: prog.push_back(addi(rd, rs1, r[26:15]));
      endcase
      prog.push_back(nopWord);
      prog.push_back(nopWord);
    end
    runProgram("random");
  endtask

  task automatic programEnd();
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd1));
    prog.push_back(addi(5'd2, 5'd0, 12'd2));
    prog.push_back(addi(5'd3, 5'd0, 12'd3));
    runProgram("programEnd");
  endtask

  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("ERROR watchdog expired after %0d cycles", watchdogCycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rstN = 1'b0;
    imemWrite = 1'b0;
    imemAddr = '0;
    imemData = '0;
    void'($urandom(83));
    resetBehavior();
    registerOps();
    zeroRegister();
    loadStore();
    randomProgram();
    programEnd();
    if (u_dut.u_checker.assertFails != 0) begin
      reportFailure("checker", $sformatf("%0d assertion failures",
                                         u_dut.u_checker.assertFails));
    end
    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/cpu_checker.sv
`default_nettype none

module cpu_checker (
  input logic              clk,
  input logic              rstN,
  input cpu_pkg::retire_t  retire
);

  // failures seen per property
  int resetFails = 0;
  int rdZeroFails = 0;
  int unknownFails = 0;
  int assertFails;

  assign assertFails = resetFails + rdZeroFails + unknownFails;

  noRetireInReset: assert property (@(posedge clk) !rstN |-> !retire.valid)
    else begin
      $error("retire valid while reset is asserted");
      resetFails++;
    end

  noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
    (retire.valid && retire.regWrite) |-> (retire.rd != '0))
    else begin
      $error("retire with regWrite set targets x0");
      rdZeroFails++;
    end

  knownRetireData: assert property (@(posedge clk) disable iff (!rstN)
    retire.valid |-> !$isunknown(retire.data))
    else begin
      $error("retire data has unknown bits");
      unknownFails++;
    end

endmodule

`default_nettype wire

// File: tests/ClockGen.sv
`default_nettype none

module ClockGen #(
  parameter int period = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: src/CPU.sv
`default_nettype none

`include "cpu_defs.svh"

module CPU (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           imemWrite,
  input  logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr,
  input  cpu_pkg::word_t                 imemData,
  output cpu_pkg::retire_t               retire
);

  cpu_pkg::ifId_t  ifId;
  cpu_pkg::idEx_t  idEx;
  cpu_pkg::exMem_t exMem;
  cpu_pkg::memWb_t memWb;

  InstructionFetch u_fetch (
    .clk(clk),
    .rstN(rstN),
    .imemWrite(imemWrite),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .ifId(ifId)
  );

  // write-back goes straight into the register file inside decode
  DecodeStage u_decode (
    .clk(clk),
    .rstN(rstN),
    .ifId(ifId),
    .wb(memWb),
    .idEx(idEx)
  );

  ExecuteStage u_execute (
    .clk(clk),
    .rstN(rstN),
    .idEx(idEx),
    .exMem(exMem)
  );

  MemoryStage u_memory (
    .clk(clk),
    .rstN(rstN),
    .exMem(exMem),
    .memWb(memWb)
  );

  // retire mirrors the write-back register
  assign retire = '{
    valid:    memWb.valid,
    regWrite: memWb.regWrite,
    rd:       memWb.rd,
    data:     memWb.data
  };

endmodule

`default_nettype wire

// File: src/MemoryStage.sv
`default_nettype none

`include "cpu_defs.svh"

module MemoryStage (
  input  logic             clk,
  input  logic             rstN,
  input  cpu_pkg::exMem_t  exMem,
  output cpu_pkg::memWb_t  memWb
);

  localparam int dmemAw = $clog2(`DMEM_DEPTH);

  cpu_pkg::word_t    dmem [`DMEM_DEPTH] = '{default: '0};
  logic [dmemAw-1:0] wordIndex;
  cpu_pkg::word_t    loadWord;
  cpu_pkg::word_t    wbData;

  // word address, byte offset dropped
  assign wordIndex = exMem.aluResult[dmemAw+1:2];

  always_ff @(posedge clk) begin
    if (exMem.valid && exMem.memWrite) begin
      dmem[wordIndex] <= exMem.storeData;
    end
  end

  // loads read combinationally in this stage
  assign loadWord = dmem[wordIndex];
  assign wbData   = exMem.memToReg ? loadWord : exMem.aluResult;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memWb <= '0;
    end else begin
      memWb.valid    <= exMem.valid;
      memWb.regWrite <= exMem.regWrite;
      memWb.rd       <= exMem.rd;
      memWb.data     <= wbData;
    end
  end

endmodule

`default_nettype wire

// File: src/ExecuteStage.sv
`default_nettype none

module ExecuteStage (
  input  logic             clk,
  input  logic             rstN,
  input  cpu_pkg::idEx_t   idEx,
  output cpu_pkg::exMem_t  exMem
);

  cpu_pkg::word_t operandA;
  cpu_pkg::word_t operandB;
  cpu_pkg::word_t aluResult;

  assign operandA = idEx.rs1Data;
  // immediate for ADDI and for load/store addresses
  assign operandB = idEx.aluSrc ? idEx.imm : idEx.rs2Data;

  always_comb begin
    case (idEx.aluOp)
      cpu_pkg::ADD: aluResult = operandA + operandB;
      cpu_pkg::SUB: aluResult = operandA - operandB;
      cpu_pkg::AND: aluResult = operandA & operandB;
      cpu_pkg::OR:  aluResult = operandA | operandB;
      cpu_pkg::XOR: aluResult = operandA ^ operandB;
      default:      aluResult = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exMem <= '0;
    end else begin
      exMem.valid     <= idEx.valid;
      exMem.memWrite  <= idEx.memWrite;
      exMem.memToReg  <= idEx.memToReg;
      exMem.regWrite  <= idEx.regWrite;
      exMem.aluResult <= aluResult;
      exMem.storeData <= idEx.rs2Data;
      exMem.rd        <= idEx.rd;
    end
  end

endmodule

`default_nettype wire

// File: src/DecodeStage.sv
`default_nettype none

module DecodeStage (
  input  logic             clk,
  input  logic             rstN,
  input  cpu_pkg::ifId_t   ifId,
  input  cpu_pkg::memWb_t  wb,
  output cpu_pkg::idEx_t   idEx
);

  // opcodes of the supported subset
  localparam logic [6:0] opReg   = 7'b0110011;
  localparam logic [6:0] opImm   = 7'b0010011;
  localparam logic [6:0] opLoad  = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;

  localparam logic [6:0] funct7Base = 7'b0000000;
  localparam logic [6:0] funct7Alt  = 7'b0100000;

  cpu_pkg::word_t     instr;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  cpu_pkg::regIndex_t rs1;
  cpu_pkg::regIndex_t rs2;
  cpu_pkg::regIndex_t rd;
  cpu_pkg::word_t     rs1Data;
  cpu_pkg::word_t     rs2Data;
  cpu_pkg::word_t     immI;
  cpu_pkg::word_t     immS;
  cpu_pkg::idEx_t     idExNext;
  logic               known;

  assign instr  = ifId.instruction;
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};

  RegisterFile u_regFile (
    .clk(clk),
    .rstN(rstN),
    .rs1(rs1),
    .rs2(rs2),
    .wb(wb),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data)
  );

  always_comb begin
    idExNext         = '0;
    known            = 1'b0;
    idExNext.aluOp   = cpu_pkg::ADD;
    idExNext.rs1Data = rs1Data;
    idExNext.rs2Data = rs2Data;

    case (opcode)
      opReg: begin
        known             = 1'b1;
        idExNext.regWrite = 1'b1;
        case ({funct7, funct3})
          {funct7Base, 3'b000}: idExNext.aluOp = cpu_pkg::ADD;
          {funct7Alt,  3'b000}: idExNext.aluOp = cpu_pkg::SUB;
          {funct7Base, 3'b111}: idExNext.aluOp = cpu_pkg::AND;
          {funct7Base, 3'b110}: idExNext.aluOp = cpu_pkg::OR;
          {funct7Base, 3'b100}: idExNext.aluOp = cpu_pkg::XOR;
          default:              known = 1'b0;
        endcase
      end
      opImm: begin
        // only ADDI from the immediate group
        known             = (funct3 == 3'b000);
        idExNext.aluSrc   = 1'b1;
        idExNext.regWrite = 1'b1;
        idExNext.imm      = immI;
      end
      opLoad: begin
        known             = (funct3 == 3'b010);
        idExNext.aluSrc   = 1'b1;
        idExNext.memToReg = 1'b1;
        idExNext.regWrite = 1'b1;
        idExNext.imm      = immI;
      end
      opStore: begin
        known             = (funct3 == 3'b010);
        idExNext.aluSrc   = 1'b1;
        idExNext.memWrite = 1'b1;
        idExNext.imm      = immS;
      end
      default: begin
        known = 1'b0;
      end
    endcase

    // stores carry immediate bits in the rd field
    idExNext.rd       = idExNext.memWrite ? '0 : rd;
    idExNext.regWrite = idExNext.regWrite && (idExNext.rd != '0);
    idExNext.valid    = ifId.valid && known;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idEx <= '0;
    end else begin
      idEx <= idExNext;
    end
  end

endmodule

`default_nettype wire

// File: src/RegisterFile.sv
`default_nettype none

`include "cpu_defs.svh"

module RegisterFile (
  input  logic                clk,
  input  logic                rstN,
  input  cpu_pkg::regIndex_t  rs1,
  input  cpu_pkg::regIndex_t  rs2,
  input  cpu_pkg::memWb_t     wb,
  output cpu_pkg::word_t      rs1Data,
  output cpu_pkg::word_t      rs2Data
);

  cpu_pkg::word_t regs [`REG_COUNT];
  logic           writeEn;

  // x0 is never written
  assign writeEn = wb.valid && wb.regWrite && (wb.rd != '0);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // one read port, with the write-through bypass
  function automatic cpu_pkg::word_t readPort(input cpu_pkg::regIndex_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (writeEn && (wb.rd == idx)) begin
      return wb.data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1Data = readPort(rs1);
    rs2Data = readPort(rs2);
  end

endmodule

`default_nettype wire

// File: src/InstructionFetch.sv
`default_nettype none

`include "cpu_defs.svh"

module InstructionFetch (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           imemWrite,
  input  logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr,
  input  cpu_pkg::word_t                 imemData,
  output cpu_pkg::ifId_t                 ifId
);

  localparam int imemAw = $clog2(`IMEM_DEPTH);

  cpu_pkg::pc_t   pc;
  cpu_pkg::word_t imem [`IMEM_DEPTH] = '{default: '0};
  cpu_pkg::word_t fetchWord;
  logic           pcInRange;

  // program load, only accepted while the core is held in reset
  always_ff @(posedge clk) begin
    if (imemWrite && !rstN) begin
      imem[imemAddr] <= imemData;
    end
  end

  // past the end of memory the fetch sees zero, which decodes as a bubble
  assign pcInRange = (pc[`XLEN-1:imemAw+2] == '0);
  assign fetchWord = pcInRange ? imem[pc[imemAw+1:2]] : '0;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc   <= '0;
      ifId <= '0;
    end else begin
      pc               <= pc + 32'd4;
      ifId.valid       <= 1'b1;
      ifId.instruction <= fetchWord;
    end
  end

endmodule

`default_nettype wire

// File: src/cpu_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

  // plain vector types with a meaning
  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`REG_COUNT)-1:0] regIndex_t;
  typedef logic [`XLEN-1:0] pc_t;

  // alu operation codes, five of them so three bits
  typedef logic [2:0] aluOp_t;

  localparam aluOp_t ADD = 3'd0;
  localparam aluOp_t SUB = 3'd1;
  localparam aluOp_t AND = 3'd2;
  localparam aluOp_t OR  = 3'd3;
  localparam aluOp_t XOR = 3'd4;

  // fetch to decode
  typedef struct packed {
    logic  valid;
    word_t instruction;
  } ifId_t;

  // decode to execute
  typedef struct packed {
    logic      valid;
    aluOp_t    aluOp;
    logic      aluSrc;
    logic      memWrite;
    logic      memToReg;
    logic      regWrite;
    word_t     rs1Data;
    word_t     rs2Data;
    word_t     imm;
    regIndex_t rd;
  } idEx_t;

  // execute to memory
  typedef struct packed {
    logic      valid;
    logic      memWrite;
    logic      memToReg;
    logic      regWrite;
    word_t     aluResult;
    word_t     storeData;
    regIndex_t rd;
  } exMem_t;

  // memory to write-back
  typedef struct packed {
    logic      valid;
    logic      regWrite;
    regIndex_t rd;
    word_t     data;
  } memWb_t;

  // retire port seen outside the core
  typedef struct packed {
    logic      valid;
    logic      regWrite;
    regIndex_t rd;
    word_t     data;
  } retire_t;

endpackage

`default_nettype wire

// File: src/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data path and instruction width
`define XLEN 32

// architectural integer registers
`define REG_COUNT 32

// instruction memory depth in 32-bit words
`define IMEM_DEPTH 64

// data memory depth in 32-bit words
`define DMEM_DEPTH 64

`endif
